//--- common/capture_pkg.sv
package capture_pkg;

    // stream widths
    localparam int S_WIDTH        = 128;
    localparam int M_WIDTH        = 64;
    localparam int WORDS_PER_BEAT = S_WIDTH / M_WIDTH;

    // sample lane layout inside one input beat
    localparam int LANES      = 8;
    localparam int LANE_WIDTH = 16;
    localparam int ADC_BITS   = 12;

    // trigger level, 10 percent of full scale
    localparam int THRESHOLD_CODE = 409;

    // beat count stamped on the trigger beat
    localparam int TS_WIDTH = 16;

    // frame shape in input beats
    localparam int PRE_BEATS   = 12;
    // trigger beat counts as the first post beat
    localparam int POST_BEATS  = 38;
    localparam int FRAME_BEATS = PRE_BEATS + POST_BEATS;

    // ring storage, power of two and large enough for one frame
    localparam int RING_DEPTH = 64;
    localparam int RING_AW    = 6;

    // two header words plus the split data words
    localparam int FRAME_WORDS = 2 + FRAME_BEATS * WORDS_PER_BEAT;

    // buffer FSM
    typedef enum logic [1:0]
    {
        ST_FILL    = 2'd0,
        ST_ARMED   = 2'd1,
        ST_COLLECT = 2'd2,
        ST_READ    = 2'd3
    } capture_state_e;

endpackage

//--- trigger/trigger_detect.sv
`timescale 1ns/1ps

module trigger_detect
    import capture_pkg::*;
(
    input  logic                AXIS_ACLK,
    input  logic                AXIS_ARESETN,
    input  logic                s_tvalid,
    input  logic [S_WIDTH-1:0]  s_tdata,
    input  logic                armed,
    output logic                det_valid,
    output logic [S_WIDTH-1:0]  det_data,
    output logic                det_trig,
    output logic [TS_WIDTH-1:0] det_ts
);

    logic [LANES-1:0]    lane_above;
    logic                above;
    logic                prev_above;
    logic                crossing;
    logic [TS_WIDTH-1:0] beat_cnt;

    // unsigned compare of the adc code in each lane
    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            lane_above[i] = (s_tdata[i*LANE_WIDTH +: ADC_BITS] >= ADC_BITS'(THRESHOLD_CODE));
        end
    end

    assign above = |lane_above;

    // rising edge of the level, only honoured while the buffer is armed
    assign crossing = s_tvalid && above && !prev_above && armed;

    // level history and beat counter, advanced on every valid beat
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            prev_above <= 1'b0;
            beat_cnt   <= '0;
        end
        else if (s_tvalid)
        begin
            prev_above <= above;
            beat_cnt   <= beat_cnt + 1'b1;
        end
    end

    // control flags of the delayed beat
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            det_valid <= 1'b0;
            det_trig  <= 1'b0;
        end
        else
        begin
            det_valid <= s_tvalid;
            det_trig  <= crossing;
        end
    end

    // payload and its stamp move with the flags above
    always_ff @(posedge AXIS_ACLK)
    begin
        det_data <= s_tdata;
        det_ts   <= beat_cnt;
    end

    // a trigger always rides on a real beat
    a_trig_has_beat: assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        det_trig |-> det_valid
    );

endmodule

//--- capture/capture_buffer.sv
`timescale 1ns/1ps

module capture_buffer
    import capture_pkg::*;
(
    input  logic                AXIS_ACLK,
    input  logic                AXIS_ARESETN,
    input  logic                det_valid,
    input  logic [S_WIDTH-1:0]  det_data,
    input  logic                det_trig,
    input  logic [TS_WIDTH-1:0] det_ts,
    input  logic                buf_ready,
    output logic                armed,
    output logic                buf_valid,
    output logic [S_WIDTH-1:0]  buf_data,
    output logic                buf_first,
    output logic                buf_last,
    output logic [TS_WIDTH-1:0] frame_ts
);

    capture_state_e state;

    logic [S_WIDTH-1:0] ring [RING_DEPTH];
    logic [RING_AW-1:0] wr_ptr;
    logic [RING_AW-1:0] rd_ptr;
    // fill count, post count or read count depending on state
    logic [RING_AW-1:0] beat_cnt;
    logic               wr_en;
    logic               rd_en;
    logic               trig_hit;

    // input is dropped while the frame is played out
    assign wr_en    = det_valid && (state != ST_READ);
    assign rd_en    = buf_valid && buf_ready;
    assign trig_hit = (state == ST_ARMED) && det_trig;

    // drop armed as soon as a trigger is in flight
    assign armed = (state == ST_ARMED) && !det_trig;

    assign buf_valid = (state == ST_READ);
    assign buf_data  = ring[rd_ptr];
    assign buf_first = (beat_cnt == '0);
    assign buf_last  = (beat_cnt == RING_AW'(FRAME_BEATS - 1));

    always_ff @(posedge AXIS_ACLK)
    begin
        if (wr_en)
        begin
            ring[wr_ptr] <= det_data;
        end
    end

    // timestamp of the frame, held until the next trigger
    always_ff @(posedge AXIS_ACLK)
    begin
        if (trig_hit)
        begin
            frame_ts <= det_ts;
        end
    end

    // write pointer runs freely, the ring overwrites old beats
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            wr_ptr <= '0;
        end
        else if (wr_en)
        begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            state    <= ST_FILL;
            rd_ptr   <= '0;
            beat_cnt <= '0;
        end
        else
        begin
            case (state)
                ST_FILL:
                begin
                    if (wr_en)
                    begin
                        if (beat_cnt == RING_AW'(PRE_BEATS - 1))
                        begin
                            state    <= ST_ARMED;
                            beat_cnt <= '0;
                        end
                        else
                        begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                ST_ARMED:
                begin
                    // trigger beat is written now as post beat one
                    if (trig_hit)
                    begin
                        state    <= ST_COLLECT;
                        rd_ptr   <= wr_ptr - RING_AW'(PRE_BEATS);
                        beat_cnt <= RING_AW'(1);
                    end
                end
                ST_COLLECT:
                begin
                    if (wr_en)
                    begin
                        if (beat_cnt == RING_AW'(POST_BEATS - 1))
                        begin
                            state    <= ST_READ;
                            beat_cnt <= '0;
                        end
                        else
                        begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                ST_READ:
                begin
                    if (rd_en)
                    begin
                        rd_ptr <= rd_ptr + 1'b1;
                        if (buf_last)
                        begin
                            state    <= ST_FILL;
                            beat_cnt <= '0;
                        end
                        else
                        begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                default:
                begin
                    state    <= ST_FILL;
                    beat_cnt <= '0;
                end
            endcase
        end
    end

    // the detector must respect armed from this module
    a_trig_only_armed: assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        det_trig |-> (state == ST_ARMED)
    );

    a_data_held: assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        (buf_valid && !buf_ready) |=> (buf_valid && $stable(buf_data))
    );

endmodule

//--- capture/stream_out.sv
`timescale 1ns/1ps

module stream_out
    import capture_pkg::*;
(
    input  logic                AXIS_ACLK,
    input  logic                AXIS_ARESETN,
    input  logic                buf_valid,
    input  logic [S_WIDTH-1:0]  buf_data,
    input  logic                buf_first,
    input  logic                buf_last,
    input  logic [TS_WIDTH-1:0] frame_ts,
    input  logic                m_tready,
    output logic                buf_ready,
    output logic                m_tvalid,
    output logic [M_WIDTH-1:0]  m_tdata,
    output logic                m_tuser,
    output logic                m_tlast
);

    logic [S_WIDTH-1:0] beat_q;
    logic               full_q;
    // 0 selects the low word, 1 the high word
    logic               half_q;
    logic               hdr_q;
    logic               last_q;
    // header of the current frame already loaded
    logic               hdr_sent_q;
    logic               slot_free;
    logic               load_hdr;
    logic               load_beat;

    // free now, or free once the high word leaves this cycle
    assign slot_free = !full_q || (half_q && m_tready);

    // the first beat waits until its header has gone in
    assign load_hdr  = slot_free && buf_valid && buf_first && !hdr_sent_q;
    assign buf_ready = slot_free && (!buf_first || hdr_sent_q);
    assign load_beat = buf_valid && buf_ready;

    assign m_tvalid = full_q;
    assign m_tdata  = half_q ? beat_q[S_WIDTH-1 -: M_WIDTH] : beat_q[M_WIDTH-1:0];
    assign m_tuser  = full_q && hdr_q && !half_q;
    assign m_tlast  = full_q && last_q && half_q;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            full_q     <= 1'b0;
            half_q     <= 1'b0;
            hdr_q      <= 1'b0;
            last_q     <= 1'b0;
            hdr_sent_q <= 1'b0;
        end
        else if (load_hdr)
        begin
            full_q     <= 1'b1;
            half_q     <= 1'b0;
            hdr_q      <= 1'b1;
            last_q     <= 1'b0;
            hdr_sent_q <= 1'b1;
        end
        else if (load_beat)
        begin
            full_q <= 1'b1;
            half_q <= 1'b0;
            hdr_q  <= 1'b0;
            last_q <= buf_last;
            // next frame needs its own header
            if (buf_last)
            begin
                hdr_sent_q <= 1'b0;
            end
        end
        else if (full_q && m_tready)
        begin
            full_q <= !half_q;
            half_q <= !half_q;
        end
    end

    // header pair is the timestamp in the low word, zero above
    always_ff @(posedge AXIS_ACLK)
    begin
        if (load_hdr)
        begin
            beat_q <= {{(S_WIDTH - TS_WIDTH){1'b0}}, frame_ts};
        end
        else if (load_beat)
        begin
            beat_q <= buf_data;
        end
    end

    a_word_held: assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        (m_tvalid && !m_tready) |=>
            (m_tvalid && $stable(m_tdata) && $stable(m_tuser) && $stable(m_tlast))
    );

endmodule

//--- hw/stream_capture_top.sv
`timescale 1ns/1ps

module stream_capture_top
    import capture_pkg::*;
(
    input  logic                AXIS_ACLK,
    input  logic                AXIS_ARESETN,
    input  logic                s_tvalid,
    input  logic [S_WIDTH-1:0]  s_tdata,
    output logic                m_tvalid,
    input  logic                m_tready,
    output logic [M_WIDTH-1:0]  m_tdata,
    output logic                m_tuser,
    output logic                m_tlast
);

    // detector to buffer
    logic                det_valid;
    logic [S_WIDTH-1:0]  det_data;
    logic                det_trig;
    logic [TS_WIDTH-1:0] det_ts;
    logic                armed;

    // buffer to output stage
    logic                buf_valid;
    logic                buf_ready;
    logic [S_WIDTH-1:0]  buf_data;
    logic                buf_first;
    logic                buf_last;
    logic [TS_WIDTH-1:0] frame_ts;

    trigger_detect u_trigger_detect (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .s_tvalid     (s_tvalid),
        .s_tdata      (s_tdata),
        .armed        (armed),
        .det_valid    (det_valid),
        .det_data     (det_data),
        .det_trig     (det_trig),
        .det_ts       (det_ts)
    );

    capture_buffer u_capture_buffer (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .det_valid    (det_valid),
        .det_data     (det_data),
        .det_trig     (det_trig),
        .det_ts       (det_ts),
        .buf_ready    (buf_ready),
        .armed        (armed),
        .buf_valid    (buf_valid),
        .buf_data     (buf_data),
        .buf_first    (buf_first),
        .buf_last     (buf_last),
        .frame_ts     (frame_ts)
    );

    stream_out u_stream_out (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .buf_valid    (buf_valid),
        .buf_data     (buf_data),
        .buf_first    (buf_first),
        .buf_last     (buf_last),
        .frame_ts     (frame_ts),
        .m_tready     (m_tready),
        .buf_ready    (buf_ready),
        .m_tvalid     (m_tvalid),
        .m_tdata      (m_tdata),
        .m_tuser      (m_tuser),
        .m_tlast      (m_tlast)
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic AXIS_ACLK,
    output logic AXIS_ARESETN
);

    localparam real HALF_PERIOD  = 50.0;
    localparam int  RESET_CYCLES = 16;

    initial
    begin
        AXIS_ACLK = 1'b0;
        forever
        begin
            #(HALF_PERIOD) AXIS_ACLK = ~AXIS_ACLK;
        end
    end

    // reset is synchronous, so release it just after an edge
    initial
    begin
        AXIS_ARESETN = 1'b0;
        repeat (RESET_CYCLES) @(posedge AXIS_ACLK);
        #1 AXIS_ARESETN = 1'b1;
    end

endmodule

//--- tb/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_value(
    input string              name,
    input logic [M_WIDTH-1:0] expected,
    input logic [M_WIDTH-1:0] actual
);
    if (actual !== expected)
    begin
        stop_with_failure($sformatf("CHECK FAILED %s expected 0x%0h actual 0x%0h",
                                    name, expected, actual));
    end
endtask

// word idx of the frame expected for a trigger at beat trig_cnt
function automatic logic [M_WIDTH-1:0] expected_word(input int trig_cnt, input int idx);
    logic [31:0]        cnt_bits;
    logic [S_WIDTH-1:0] beat_data;
    int                 beat;
    cnt_bits = trig_cnt;
    if (idx == 0)
    begin
        expected_word = {{(M_WIDTH - TS_WIDTH){1'b0}}, cnt_bits[TS_WIDTH-1:0]};
    end
    else if (idx == 1)
    begin
        expected_word = '0;
    end
    else
    begin
        // oldest pre-trigger beat first, low half before high half
        beat      = trig_cnt - PRE_BEATS + (idx - 2) / 2;
        beat_data = history[beat % HIST_DEPTH];
        if ((idx - 2) % 2 == 0)
        begin
            expected_word = beat_data[M_WIDTH-1:0];
        end
        else
        begin
            expected_word = beat_data[S_WIDTH-1 -: M_WIDTH];
        end
    end
endfunction

// random codes below the level, random upper nibble
function automatic logic [S_WIDTH-1:0] quiet_data();
    logic [S_WIDTH-1:0] beat_data;
    logic [31:0]        rnd;
    logic [31:0]        code;
    for (int i = 0; i < LANES; i++)
    begin
        rnd  = $random(seed);
        code = $unsigned($random(seed)) % THRESHOLD_CODE;
        beat_data[i*LANE_WIDTH +: LANE_WIDTH] = {rnd[LANE_WIDTH-1:ADC_BITS],
                                                 code[ADC_BITS-1:0]};
    end
    quiet_data = beat_data;
endfunction

// full scale code in one lane
function automatic logic [S_WIDTH-1:0] pulse_data();
    logic [S_WIDTH-1:0] beat_data;
    int                 lane;
    beat_data = quiet_data();
    lane      = $unsigned($random(seed)) % LANES;
    beat_data[lane*LANE_WIDTH +: LANE_WIDTH] = {{(LANE_WIDTH - ADC_BITS){1'b0}},
                                                {ADC_BITS{1'b1}}};
    pulse_data = beat_data;
endfunction

task automatic send_beat(input logic [S_WIDTH-1:0] beat_data);
    @(posedge AXIS_ACLK);
    #1;
    s_tvalid = 1'b1;
    s_tdata  = beat_data;
    history[beat_count % HIST_DEPTH] = beat_data;
    beat_count++;
endtask

task automatic idle_cycles(input int n);
    repeat (n)
    begin
        @(posedge AXIS_ACLK);
        #1;
        s_tvalid = 1'b0;
    end
endtask

task automatic send_quiet(input int n);
    repeat (n)
    begin
        send_beat(quiet_data());
    end
endtask

// pulse that must start a frame stamped with its beat count
task automatic send_trigger();
    expected_ts.push_back(beat_count);
    send_beat(pulse_data());
endtask

// beats sent while waiting are dropped during readout, but still counted
task automatic finish_frame(input bit keep_sending);
    int start;
    start = frames_seen;
    while (frames_seen == start)
    begin
        if (keep_sending)
        begin
            send_beat(quiet_data());
        end
        else
        begin
            idle_cycles(1);
        end
    end
    idle_cycles(4);
endtask

`endif

//--- tb/tb_stream_capture.sv
`timescale 1ns/1ps

module tb_stream_capture
    import capture_pkg::*;
();

    localparam int          HIST_DEPTH     = 4096;
    // about four times 7 frames at a worst case of ~700 cycles each
    localparam int          TIMEOUT_CYCLES = 20000;
    localparam logic [31:0] SEED           = 32'he9d4fca4;

    logic               AXIS_ACLK;
    logic               AXIS_ARESETN;
    logic               s_tvalid;
    logic [S_WIDTH-1:0] s_tdata;
    logic               m_tvalid;
    logic               m_tready;
    logic [M_WIDTH-1:0] m_tdata;
    logic               m_tuser;
    logic               m_tlast;

    integer             seed;
    integer             ready_seed;
    logic [31:0]        ready_rnd;
    logic               bp_on;
    string              test_name;

    // every beat sent, indexed by its beat count
    logic [S_WIDTH-1:0] history [HIST_DEPTH];
    int                 beat_count      = 0;
    int                 expected_ts [$];
    int                 frames_seen     = 0;
    int                 word_idx        = 0;
    int                 cycle_count     = 0;
    // {tlast, tuser, tdata} of each accepted word
    logic [M_WIDTH+1:0] word_q [$];
    logic [M_WIDTH+1:0] got_word;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    `include "tb_checks.svh"

    tb_clock_gen u_clock_gen (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN)
    );

    stream_capture_top u_dut (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .s_tvalid     (s_tvalid),
        .s_tdata      (s_tdata),
        .m_tvalid     (m_tvalid),
        .m_tready     (m_tready),
        .m_tdata      (m_tdata),
        .m_tuser      (m_tuser),
        .m_tlast      (m_tlast)
    );

    // sink ready, random only while back-pressure is on
    initial
    begin
        ready_seed = SEED;
        m_tready   = 1'b1;
        forever
        begin
            @(posedge AXIS_ACLK);
            #1;
            if (bp_on)
            begin
                ready_rnd = $random(ready_seed);
                m_tready  = ready_rnd[0];
            end
            else
            begin
                m_tready = 1'b1;
            end
        end
    end

    always @(posedge AXIS_ACLK)
    begin
        if (AXIS_ARESETN && m_tvalid && m_tready)
        begin
            word_q.push_back({m_tlast, m_tuser, m_tdata});
        end
    end

    // compare at the falling edge, away from the sampling edge
    always @(negedge AXIS_ACLK)
    begin
        while (word_q.size() > 0)
        begin
            if (expected_ts.size() == 0)
            begin
                stop_with_failure("an output word arrived while no frame was expected");
            end
            else
            begin
                got_word = word_q.pop_front();
                check_value($sformatf("%s word %0d data", test_name, word_idx),
                            expected_word(expected_ts[0], word_idx), got_word[M_WIDTH-1:0]);
                check_value($sformatf("%s word %0d tuser", test_name, word_idx),
                            (word_idx == 0), got_word[M_WIDTH]);
                check_value($sformatf("%s word %0d tlast", test_name, word_idx),
                            (word_idx == FRAME_WORDS - 1), got_word[M_WIDTH+1]);
                if (word_idx == FRAME_WORDS - 1)
                begin
                    void'(expected_ts.pop_front());
                    frames_seen++;
                    word_idx = 0;
                end
                else
                begin
                    word_idx++;
                end
            end
        end
    end

    always @(posedge AXIS_ACLK)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            stop_with_failure("timeout, the run hung before all frames came out");
        end
    end

    initial
    begin
        seed      = SEED;
        s_tvalid  = 1'b0;
        s_tdata   = '0;
        bp_on     = 1'b0;
        test_name = "reset";
        wait (AXIS_ARESETN === 1'b1);
        check_value("reset m_tvalid", 0, m_tvalid);
        check_value("reset m_tuser", 0, m_tuser);
        check_value("reset m_tlast", 0, m_tlast);

        // pulse at beat 5 comes before the ring is armed
        test_name = "arming";
        send_quiet(5);
        send_beat(pulse_data());
        send_quiet(24);
        send_trigger();
        send_quiet(POST_BEATS - 1);
        finish_frame(1'b0);

        test_name = "basic frame";
        send_quiet(20);
        send_trigger();
        send_quiet(POST_BEATS - 1);
        finish_frame(1'b0);

        // ten beats above the level, then a second pulse among the post beats
        test_name = "crossing only";
        send_quiet(20);
        send_trigger();
        repeat (9)
        begin
            send_beat(pulse_data());
        end
        send_quiet(10);
        send_beat(pulse_data());
        finish_frame(1'b1);
        // level still above when the ring arms again, no new frame
        repeat (PRE_BEATS + 4)
        begin
            send_beat(pulse_data());
        end

        test_name = "back-pressure";
        bp_on     = 1'b1;
        send_quiet(20);
        send_trigger();
        finish_frame(1'b1);
        bp_on = 1'b0;

        for (int i = 0; i < 3; i++)
        begin
            test_name = $sformatf("repeated frame %0d", i);
            send_quiet(PRE_BEATS + 8);
            send_trigger();
            finish_frame(1'b1);
        end

        // room for a stray frame to show up
        test_name = "end";
        idle_cycles(300);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+tb
common/capture_pkg.sv
trigger/trigger_detect.sv
capture/capture_buffer.sv
capture/stream_out.sv
hw/stream_capture_top.sv
tb/tb_clock_gen.sv
tb/tb_stream_capture.sv
